/* logic/snakeMover.sv */
// snake mover: tick timing, direction latch, body registers, collision and square commands
`timescale 1ns/100ps

module snakeMover #(
    parameter int SquareSize = 4,
    parameter int SnakeLength = 6,
    parameter int TickCycles = 64,
    parameter snakePkg::xCoord_t StartX = 8'd80,
    parameter snakePkg::yCoord_t StartY = 7'd60,
    parameter snakePkg::xCoord_t AppleX = 8'd28,
    parameter snakePkg::yCoord_t AppleY = 7'd28,
    parameter snakePkg::direction_t StartDir = snakePkg::DirRight
) (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 start,
    input  snakePkg::keys_t      keys,
    input  snakePkg::colour_t    snakeColour,
    output snakePkg::squareCmd_t cmd,
    output logic                 cmdValid,
    input  logic                 cmdReady,
    output logic                 gameOver
);

    localparam int TickWidth = $clog2(TickCycles + 1);
    localparam int IndexWidth = $clog2(SnakeLength + 1);

    typedef enum logic [2:0] {
        Idle,
        InitDraw,
        WaitTick,
        EraseTail,
        MoveCheck,
        DrawHead,
        Over
    } state_t;

    state_t state;
    snakePkg::direction_t direction;
    // segment 0 is the head
    snakePkg::xCoord_t segX [SnakeLength];
    snakePkg::yCoord_t segY [SnakeLength];
    snakePkg::colour_t drawColour;
    logic [TickWidth-1:0] tickCount;
    logic [3:0] pendingTicks;
    // 0 is the apple, then segments head to tail
    logic [IndexWidth-1:0] drawIndex;
    logic tick;
    logic running;
    logic takeTick;
    logic cmdTaken;
    logic wallHit;
    logic bodyHit;
    int nextX;
    int nextY;

    // free running tick divider
    assign tick = (tickCount == TickWidth'(TickCycles - 1));

    always_ff @(posedge Clock)
    begin
        if (reset || tick)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    // ticks only count while a game is on
    assign running = (state != Idle) && (state != Over);
    assign takeTick = (state == WaitTick) && (pendingTicks != '0);

    // backlog of ticks not yet serviced, saturating
    always_ff @(posedge Clock)
    begin
        if (reset)
            pendingTicks <= '0;
        else if (tick && running && !takeTick && pendingTicks != '1)
            pendingTicks <= pendingTicks + 1'b1;
        else if (takeTick && !(tick && running))
            pendingTicks <= pendingTicks - 1'b1;
    end

    // key priority right, down, up, left
    always_ff @(posedge Clock)
    begin
        if (reset)
            direction <= StartDir;
        else if (keys.right)
            direction <= snakePkg::DirRight;
        else if (keys.down)
            direction <= snakePkg::DirDown;
        else if (keys.up)
            direction <= snakePkg::DirUp;
        else if (keys.left)
            direction <= snakePkg::DirLeft;
    end

    // candidate head one square ahead, signed so walls show as out of range
    always_comb
    begin
        nextX = int'(segX[0]);
        nextY = int'(segY[0]);
        case (direction)
            snakePkg::DirRight: nextX = nextX + SquareSize;
            snakePkg::DirDown: nextY = nextY + SquareSize;
            snakePkg::DirUp: nextY = nextY - SquareSize;
            default: nextX = nextX - SquareSize;
        endcase
        wallHit = (nextX < 0) || (nextX > snakePkg::ScreenWidth - SquareSize)
            || (nextY < 0) || (nextY > snakePkg::ScreenHeight - SquareSize);
        bodyHit = 1'b0;
        // tail excluded, it moves away this tick
        for (int i = 0; i < SnakeLength - 1; i++)
        begin
            if (segX[i] == snakePkg::xCoord_t'(nextX) && segY[i] == snakePkg::yCoord_t'(nextY))
                bodyHit = 1'b1;
        end
    end

    assign cmdTaken = cmdValid && cmdReady;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= Idle;
            drawIndex <= '0;
            gameOver <= 1'b0;
        end
        else
        begin
            case (state)
                Idle:
                    if (start)
                    begin
                        state <= InitDraw;
                        drawIndex <= '0;
                    end
                InitDraw:
                    if (cmdTaken)
                    begin
                        if (drawIndex == IndexWidth'(SnakeLength))
                            state <= WaitTick;
                        drawIndex <= drawIndex + 1'b1;
                    end
                WaitTick:
                    if (takeTick)
                        state <= EraseTail;
                EraseTail:
                    if (cmdTaken)
                        state <= MoveCheck;
                MoveCheck:
                    if (wallHit || bodyHit)
                    begin
                        state <= Over;
                        gameOver <= 1'b1;
                    end
                    else
                        state <= DrawHead;
                DrawHead:
                    if (cmdTaken)
                        state <= WaitTick;
                default:
                    state <= Over;
            endcase
        end
    end

    // body loaded on start, shifted head-first on a clean move
    always_ff @(posedge Clock)
    begin
        if (state == Idle && start)
        begin
            drawColour <= snakeColour;
            for (int i = 0; i < SnakeLength; i++)
            begin
                segX[i] <= snakePkg::xCoord_t'(int'(StartX) - i * SquareSize);
                segY[i] <= StartY;
            end
        end
        else if (state == MoveCheck && !(wallHit || bodyHit))
        begin
            segX[0] <= snakePkg::xCoord_t'(nextX);
            segY[0] <= snakePkg::yCoord_t'(nextY);
            for (int i = 1; i < SnakeLength; i++)
            begin
                segX[i] <= segX[i-1];
                segY[i] <= segY[i-1];
            end
        end
    end

    // square command out of state and registers only
    always_comb
    begin
        cmd = '0;
        cmdValid = 1'b0;
        case (state)
            InitDraw:
            begin
                cmdValid = 1'b1;
                if (drawIndex == '0)
                begin
                    cmd.x = AppleX;
                    cmd.y = AppleY;
                    cmd.colour = snakePkg::AppleColour;
                end
                else
                begin
                    cmd.x = segX[drawIndex - 1'b1];
                    cmd.y = segY[drawIndex - 1'b1];
                    cmd.colour = drawColour;
                end
            end
            EraseTail:
            begin
                cmdValid = 1'b1;
                cmd.x = segX[SnakeLength-1];
                cmd.y = segY[SnakeLength-1];
                cmd.colour = snakePkg::EraseColour;
            end
            DrawHead:
            begin
                cmdValid = 1'b1;
                cmd.x = segX[0];
                cmd.y = segY[0];
                cmd.colour = drawColour;
            end
            default:
                cmdValid = 1'b0;
        endcase
    end

    // a stalled command holds until the FIFO takes it
    assert property (@(posedge Clock) disable iff (reset)
        cmdValid && !cmdReady |=> cmdValid && $stable(cmd))
        else $error("snakeMover: cmd changed while stalled");

    // game over is sticky until reset
    assert property (@(posedge Clock) disable iff (reset) gameOver |=> gameOver)
        else $error("snakeMover: gameOver fell without reset");

endmodule

/* logic/snakePkg.sv */
// snake game shared definitions: screen size, coordinates, colours and stream words
package snakePkg;

    // frame buffer size in pixels
    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;

    // pixel coordinates and 3-bit rgb
    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;
    typedef logic [2:0] colour_t;

    // fixed colours, black background and red apple
    localparam colour_t EraseColour = 3'b000;
    localparam colour_t AppleColour = 3'b100;

    // heading of the snake head
    typedef enum logic [1:0] {
        DirRight,
        DirDown,
        DirUp,
        DirLeft
    } direction_t;

    // one request bit per arrow key, active high
    typedef struct packed {
        logic right;
        logic down;
        logic up;
        logic left;
    } keys_t;

    // top-left corner of one square to paint
    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
        colour_t colour;
    } squareCmd_t;

    // one frame buffer write
    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
        colour_t colour;
    } pixel_t;

endpackage

/* logic/snakeTop.sv */
// snake game top: mover feeds a square FIFO that feeds the pixel rasterizer
`timescale 1ns/100ps

module snakeTop #(
    parameter int SquareSize = 4,
    parameter int SnakeLength = 6,
    // about one million on hardware
    parameter int TickCycles = 64,
    parameter int FifoDepth = 4,
    parameter snakePkg::xCoord_t StartX = 8'd80,
    parameter snakePkg::yCoord_t StartY = 7'd60,
    parameter snakePkg::xCoord_t AppleX = 8'd28,
    parameter snakePkg::yCoord_t AppleY = 7'd28,
    parameter snakePkg::direction_t StartDir = snakePkg::DirRight
) (
    input  logic              Clock,
    input  logic              reset,
    input  logic              start,
    input  snakePkg::keys_t   keys,
    input  snakePkg::colour_t snakeColour,
    output snakePkg::pixel_t  pixel,
    output logic              pixelValid,
    input  logic              pixelReady,
    output logic              gameOver
);

    // mover to FIFO
    snakePkg::squareCmd_t moverCmd;
    logic moverValid;
    logic moverReady;
    // FIFO to rasterizer
    snakePkg::squareCmd_t rasterCmd;
    logic rasterValid;
    logic rasterReady;

    snakeMover #(
        .SquareSize(SquareSize),
        .SnakeLength(SnakeLength),
        .TickCycles(TickCycles),
        .StartX(StartX),
        .StartY(StartY),
        .AppleX(AppleX),
        .AppleY(AppleY),
        .StartDir(StartDir)
    ) mover (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .keys(keys),
        .snakeColour(snakeColour),
        .cmd(moverCmd),
        .cmdValid(moverValid),
        .cmdReady(moverReady),
        .gameOver(gameOver)
    );

    squareFifo #(
        .FifoDepth(FifoDepth)
    ) squareBuffer (
        .Clock(Clock),
        .reset(reset),
        .inCmd(moverCmd),
        .inValid(moverValid),
        .inReady(moverReady),
        .outCmd(rasterCmd),
        .outValid(rasterValid),
        .outReady(rasterReady)
    );

    squareRasterizer #(
        .SquareSize(SquareSize)
    ) rasterizer (
        .Clock(Clock),
        .reset(reset),
        .cmd(rasterCmd),
        .cmdValid(rasterValid),
        .cmdReady(rasterReady),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .pixelReady(pixelReady)
    );

endmodule

/* logic/squareFifo.sv */
// square FIFO: circular buffer of square commands between mover and rasterizer
`timescale 1ns/100ps

module squareFifo #(
    parameter int FifoDepth = 4
) (
    input  logic                 Clock,
    input  logic                 reset,
    input  snakePkg::squareCmd_t inCmd,
    input  logic                 inValid,
    output logic                 inReady,
    output snakePkg::squareCmd_t outCmd,
    output logic                 outValid,
    input  logic                 outReady
);

    // depth of at least two
    localparam int PtrWidth = $clog2(FifoDepth);
    localparam int CountWidth = $clog2(FifoDepth + 1);

    snakePkg::squareCmd_t storage [FifoDepth];
    logic [PtrWidth-1:0] writePtr;
    logic [PtrWidth-1:0] readPtr;
    logic [CountWidth-1:0] count;
    logic pushing;
    logic popping;

    assign inReady = (count != CountWidth'(FifoDepth));
    assign outValid = (count != '0);
    assign outCmd = storage[readPtr];

    assign pushing = inValid && inReady;
    assign popping = outValid && outReady;

    // entries carry no reset
    always_ff @(posedge Clock)
    begin
        if (pushing)
            storage[writePtr] <= inCmd;
    end

    // pointers wrap at depth, any depth works
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            writePtr <= '0;
            readPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (pushing)
                writePtr <= (writePtr == PtrWidth'(FifoDepth - 1)) ? '0 : writePtr + 1'b1;
            if (popping)
                readPtr <= (readPtr == PtrWidth'(FifoDepth - 1)) ? '0 : readPtr + 1'b1;
            if (pushing && !popping)
                count <= count + 1'b1;
            else if (popping && !pushing)
                count <= count - 1'b1;
        end
    end

    // occupancy bounded by depth
    assert property (@(posedge Clock) disable iff (reset) count <= CountWidth'(FifoDepth))
        else $error("squareFifo: count above depth");

endmodule

/* logic/squareRasterizer.sv */
// square rasterizer: walks each square command row by row into single pixel writes
`timescale 1ns/100ps

module squareRasterizer #(
    parameter int SquareSize = 4
) (
    input  logic                 Clock,
    input  logic                 reset,
    input  snakePkg::squareCmd_t cmd,
    input  logic                 cmdValid,
    output logic                 cmdReady,
    output snakePkg::pixel_t     pixel,
    output logic                 pixelValid,
    input  logic                 pixelReady
);

    // square size is a power of two, at least two
    localparam int OffsetWidth = $clog2(SquareSize);

    snakePkg::squareCmd_t current;
    logic busy;
    logic [OffsetWidth-1:0] colOffset;
    logic [OffsetWidth-1:0] rowOffset;
    logic lastCol;
    logic lastRow;
    logic cmdTaken;
    logic pixelTaken;

    // one square at a time
    assign cmdReady = !busy;
    assign pixelValid = busy;

    assign cmdTaken = cmdValid && cmdReady;
    assign pixelTaken = pixelValid && pixelReady;

    assign lastCol = (colOffset == OffsetWidth'(SquareSize - 1));
    assign lastRow = (rowOffset == OffsetWidth'(SquareSize - 1));

    // corner of the square being drawn
    always_ff @(posedge Clock)
    begin
        if (cmdTaken)
            current <= cmd;
    end

    // x fastest, then y
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            colOffset <= '0;
            rowOffset <= '0;
        end
        else if (cmdTaken)
        begin
            busy <= 1'b1;
            colOffset <= '0;
            rowOffset <= '0;
        end
        else if (pixelTaken)
        begin
            if (lastCol)
            begin
                colOffset <= '0;
                if (lastRow)
                begin
                    // last pixel ends the square
                    rowOffset <= '0;
                    busy <= 1'b0;
                end
                else
                    rowOffset <= rowOffset + 1'b1;
            end
            else
                colOffset <= colOffset + 1'b1;
        end
    end

    // pixel address is corner plus offsets
    always_comb
    begin
        pixel.x = current.x + snakePkg::xCoord_t'(colOffset);
        pixel.y = current.y + snakePkg::yCoord_t'(rowOffset);
        pixel.colour = current.colour;
    end

    // waiting pixel holds still
    assert property (@(posedge Clock) disable iff (reset)
        pixelValid && !pixelReady |=> pixelValid && $stable(pixel))
        else $error("squareRasterizer: pixel changed under back-pressure");

endmodule

/* run.sh */
#!/bin/sh
# build the snake testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert -Wno-fatal --top-module snakeTb \
    -f snakeGame.f -o snakeSim || exit 1
./obj_dir/snakeSim | tee /dev/stderr | grep -q "Testbench passed" && exit 0 || exit 1

/* snakeGame.f */
logic/snakePkg.sv
logic/snakeMover.sv
logic/squareFifo.sv
logic/squareRasterizer.sv
logic/snakeTop.sv
testbench/snakeChecker.sv
testbench/snakeTb.sv

/* testbench/snakeChecker.sv */
// snake checker: rebuilds squares from the pixel stream and compares them with the expected game
`timescale 1ns/100ps

module snakeChecker #(
    parameter int SquareSize = 4,
    parameter int SnakeLength = 6,
    parameter int StartX = 80,
    parameter int StartY = 60,
    parameter int AppleX = 28,
    parameter int AppleY = 28
) (
    input  logic              Clock,
    input  logic              reset,
    input  logic              start,
    input  snakePkg::colour_t snakeColour,
    input  snakePkg::pixel_t  pixel,
    input  logic              pixelValid,
    input  logic              pixelReady,
    input  logic              gameOver,
    input  int                expHeadX,
    input  int                expHeadY,
    input  logic              expGameOver,
    output logic              initDone,
    output int                ticksDone,
    output int                valueErrors,
    output int                protocolErrors
);

    localparam int PhaseIdle = 0;
    localparam int PhaseInit = 1;
    localparam int PhaseTicks = 2;
    localparam int PhaseOver = 3;

    // squares still due, oldest first
    snakePkg::squareCmd_t expectedSquares[$];
    string squareNames[$];
    // body as the vectors move it, head first
    int bodyX[$];
    int bodyY[$];
    snakePkg::squareCmd_t current;
    string currentName;
    snakePkg::colour_t drawColour;
    snakePkg::pixel_t heldPixel;
    int phase = PhaseIdle;
    int pixIndex = 0;
    int tickNumber = 0;
    bit tickCollides = 1'b0;
    bit stalled = 1'b0;
    bit dropReported = 1'b0;
    logic initSeen = 1'b0;
    int tickCount = 0;
    int valueCount = 0;
    int protocolCount = 0;

    assign initDone = initSeen;
    assign ticksDone = tickCount;
    assign valueErrors = valueCount;
    assign protocolErrors = protocolCount;

    task automatic compareValue(string name, int expectedValue, int actualValue);
        if (expectedValue != actualValue)
        begin
            valueCount++;
            $display("Fail %s: expected %0d, actual %0d", name, expectedValue, actualValue);
        end
    endtask

    task automatic protocolError(string what);
        protocolCount++;
        $display("Error: %s at time %0t", what, $time);
    endtask

    task automatic pushSquare(int x, int y, snakePkg::colour_t colour, string name);
        snakePkg::squareCmd_t square;
        square.x = snakePkg::xCoord_t'(x);
        square.y = snakePkg::yCoord_t'(y);
        square.colour = colour;
        expectedSquares.push_back(square);
        squareNames.push_back(name);
    endtask

    // apple first, then the body from head to tail
    task automatic loadInitialDraw();
        drawColour = snakeColour;
        pushSquare(AppleX, AppleY, snakePkg::AppleColour, "initial apple");
        for (int i = 0; i < SnakeLength; i++)
        begin
            bodyX.push_back(StartX - i * SquareSize);
            bodyY.push_back(StartY);
            pushSquare(StartX - i * SquareSize, StartY, drawColour,
                $sformatf("initial segment %0d", i));
        end
        tickNumber = 0;
        phase = PhaseInit;
    endtask

    // old tail goes black, new head from the vector unless this tick collides
    task automatic queueTick();
        tickNumber++;
        tickCollides = expGameOver;
        pushSquare(bodyX[bodyX.size() - 1], bodyY[bodyY.size() - 1], snakePkg::EraseColour,
            $sformatf("tick %0d erase", tickNumber));
        if (!expGameOver)
        begin
            pushSquare(expHeadX, expHeadY, drawColour, $sformatf("tick %0d draw", tickNumber));
            bodyX.push_front(expHeadX);
            bodyY.push_front(expHeadY);
            void'(bodyX.pop_back());
            void'(bodyY.pop_back());
        end
    endtask

    task automatic finishSquare();
        if (expectedSquares.size() == 0)
        begin
            if (phase == PhaseInit)
            begin
                initSeen = 1'b1;
                phase = PhaseTicks;
            end
            else
            begin
                compareValue($sformatf("tick %0d gameOver", tickNumber),
                    int'(tickCollides), int'(gameOver));
                tickCount++;
                if (tickCollides)
                    phase = PhaseOver;
            end
        end
    endtask

    // pixels of a square arrive row-major from its corner
    task automatic takePixel();
        int expX;
        int expY;
        if (pixIndex == 0 && phase == PhaseIdle)
            protocolError("pixel written before the game started");
        else if (pixIndex == 0 && phase == PhaseOver)
            protocolError("pixel written after game over");
        else
        begin
            if (pixIndex == 0)
            begin
                if (expectedSquares.size() == 0)
                    queueTick();
                current = expectedSquares.pop_front();
                currentName = squareNames.pop_front();
            end
            expX = int'(current.x) + pixIndex % SquareSize;
            expY = int'(current.y) + pixIndex / SquareSize;
            compareValue($sformatf("%s pixel %0d x", currentName, pixIndex), expX, int'(pixel.x));
            compareValue($sformatf("%s pixel %0d y", currentName, pixIndex), expY, int'(pixel.y));
            compareValue($sformatf("%s pixel %0d colour", currentName, pixIndex),
                int'(current.colour), int'(pixel.colour));
            if (pixIndex == SquareSize * SquareSize - 1)
            begin
                pixIndex = 0;
                finishSquare();
            end
            else
                pixIndex++;
        end
    endtask

    always @(posedge Clock)
    begin
        if (reset)
        begin
            expectedSquares.delete();
            squareNames.delete();
            bodyX.delete();
            bodyY.delete();
            phase = PhaseIdle;
            pixIndex = 0;
            initSeen = 1'b0;
            stalled = 1'b0;
            dropReported = 1'b0;
        end
        else
        begin
            // a waiting pixel must stay put
            if (stalled && (!pixelValid || pixel != heldPixel))
                protocolError("pixel changed or vanished while waiting for pixelReady");
            stalled = pixelValid && !pixelReady;
            heldPixel = pixel;
            if (phase == PhaseOver && !gameOver && !dropReported)
            begin
                protocolError("gameOver fell before reset");
                dropReported = 1'b1;
            end
            if (start && phase == PhaseIdle)
                loadInitialDraw();
            if (pixelValid && pixelReady)
                takePixel();
        end
    end

endmodule

/* testbench/snakeTb.sv */
// snake testbench: plays vector games on the snake core under random pixel back-pressure
`timescale 1ns/100ps

module snakeTb;

    localparam int SquareSize = 4;
    localparam int SnakeLength = 6;
    // long tick, both squares of a tick drain before the next one
    localparam int TickCycles = 512;
    localparam int FifoDepth = 4;
    localparam int ResetCycles = 8;
    // idle gap between reset and start
    localparam int IdleCycles = 4;
    localparam int WaitLimit = 4 * TickCycles;
    // several tick periods of silence after a collision
    localparam int QuietCycles = 4 * TickCycles;

    logic Clock;
    logic reset;
    logic start;
    snakePkg::keys_t keys;
    snakePkg::colour_t snakeColour;
    snakePkg::pixel_t pixel;
    logic pixelValid;
    logic pixelReady;
    logic gameOver;

    // current vector, seen by the checker
    int expHeadX;
    int expHeadY;
    logic expGameOver;
    logic initDone;
    int ticksDone;
    int valueErrors;
    int protocolErrors;
    int runErrors;
    int vectorsRun;
    int vectorFile;
    int seed;

    snakeTop #(
        .SquareSize(SquareSize),
        .SnakeLength(SnakeLength),
        .TickCycles(TickCycles),
        .FifoDepth(FifoDepth)
    ) DUT (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .keys(keys),
        .snakeColour(snakeColour),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .pixelReady(pixelReady),
        .gameOver(gameOver)
    );

    snakeChecker #(
        .SquareSize(SquareSize),
        .SnakeLength(SnakeLength)
    ) pixelChecker (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .snakeColour(snakeColour),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .pixelReady(pixelReady),
        .gameOver(gameOver),
        .expHeadX(expHeadX),
        .expHeadY(expHeadY),
        .expGameOver(expGameOver),
        .initDone(initDone),
        .ticksDone(ticksDone),
        .valueErrors(valueErrors),
        .protocolErrors(protocolErrors)
    );

    // 20 ns period
    initial
    begin
        Clock = 1'b0;
        forever
            #10 Clock = ~Clock;
    end

    // pixelReady high about three cycles in four
    initial
    begin
        seed = 73;
        pixelReady = 1'b0;
        forever
        begin
            @(negedge Clock);
            pixelReady = (($random(seed) & 3) != 0);
        end
    end

    task automatic applyReset();
        reset = 1'b1;
        repeat (ResetCycles) @(negedge Clock);
        reset = 1'b0;
    endtask

    // idle gap, one cycle start pulse, then wait for apple and body
    task automatic startGame(int gameIndex);
        int cycles;
        snakeColour = snakePkg::colour_t'(2 + gameIndex % 2);
        // the checker flags any pixel in this gap
        cycles = 0;
        while (cycles < IdleCycles)
        begin
            @(negedge Clock);
            cycles++;
        end
        start = 1'b1;
        @(negedge Clock);
        start = 1'b0;
        cycles = 0;
        while (!initDone && cycles < WaitLimit)
        begin
            @(negedge Clock);
            cycles++;
        end
        if (!initDone)
        begin
            runErrors++;
            $display("Error: initial draw of game %0d did not finish in %0d cycles",
                gameIndex, WaitLimit);
        end
    endtask

    task automatic waitForTick(int tickBase);
        int cycles;
        cycles = 0;
        while (ticksDone == tickBase && cycles < WaitLimit)
        begin
            @(negedge Clock);
            cycles++;
        end
        if (ticksDone == tickBase)
        begin
            runErrors++;
            $display("Error: tick %0d gave no squares in %0d cycles", tickBase + 1, WaitLimit);
        end
    endtask

    // the checker flags any pixel in this window
    task automatic holdQuiet();
        int cycles;
        cycles = 0;
        while (cycles < QuietCycles)
        begin
            @(negedge Clock);
            cycles++;
        end
    endtask

    task automatic runVectors();
        string line;
        int fields;
        int keyValue;
        int headX;
        int headY;
        int over;
        int tickBase;
        int gameIndex;
        bit newGame;
        newGame = 1'b1;
        gameIndex = 0;
        while (runErrors == 0 && $fgets(line, vectorFile) != 0)
        begin
            // comment and blank lines do not parse
            fields = $sscanf(line, "%h %d %d %d", keyValue, headX, headY, over);
            if (fields == 4)
            begin
                if (newGame)
                    applyReset();
                keys = snakePkg::keys_t'(keyValue[3:0]);
                expHeadX = headX;
                expHeadY = headY;
                expGameOver = (over != 0);
                tickBase = ticksDone;
                if (newGame)
                begin
                    startGame(gameIndex);
                    gameIndex++;
                    newGame = 1'b0;
                end
                if (runErrors == 0)
                    waitForTick(tickBase);
                if (runErrors == 0 && over != 0)
                begin
                    holdQuiet();
                    newGame = 1'b1;
                end
                vectorsRun++;
            end
        end
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        keys = '0;
        snakeColour = 3'b010;
        expHeadX = 0;
        expHeadY = 0;
        expGameOver = 1'b0;
        runErrors = 0;
        vectorsRun = 0;
        vectorFile = $fopen("testbench/snakeVectors.txt", "r");
        if (vectorFile == 0)
        begin
            runErrors++;
            $display("Error: could not open testbench/snakeVectors.txt");
        end
        else
        begin
            runVectors();
            $fclose(vectorFile);
            if (vectorsRun == 0)
            begin
                runErrors++;
                $display("Error: vector file held no vectors");
            end
        end
        $display("Errors: value %0d, protocol %0d, run %0d",
            valueErrors, protocolErrors, runErrors);
        if (valueErrors + protocolErrors + runErrors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* testbench/snakeVectors.txt */
# keys in hex (bit 3 right, 2 down, 1 up, 0 left), expected head x, head y, gameOver
# gameOver 1 ends a game with the head unchanged; the next line starts a new game after reset
8 84 60 0
9 88 60 0
4 88 64 0
0 88 68 0
1 84 68 0
2 84 64 0
8 84 64 1
2 80 56 0
0 80 52 0
0 80 48 0
1 76 48 0
0 72 48 0
2 72 44 0
0 72 40 0
0 72 36 0
0 72 32 0
0 72 28 0
0 72 24 0
0 72 20 0
0 72 16 0
0 72 12 0
0 72 8 0
0 72 4 0
0 72 0 0
0 72 0 1
